// ==== bench/tb_wr_shim.sv ====
// ********************
// Directed testbench for the write-path clock-crossing shim
// Drives request beats on afu_clk and responses on bb_clk, watches both outputs
// Prints one line per test and a closing summary
// ********************

`timescale 1ns/1ps
`default_nettype none

module tb_wr_shim
    import wr_shim_pkg::*;
();

    localparam int AFU_HALF     = 10;
    localparam int BB_HALF      = 7;
    localparam int RESET_CYCLES = 5;
    // Rough afu_clk cycles that all five tests take together
    localparam int TEST_CYCLES  = 400;
    localparam int WATCHDOG_NS  = TEST_CYCLES * 2 * AFU_HALF * 4;

    logic      afu_clk;
    logic      bb_clk;
    logic      afu_softreset;
    wr_beat_t  afu_tx;
    logic      bb_almfull;
    wr_rsp_t   bb_rsp;
    wr_beat_t  bb_tx;
    wr_rsp_t   afu_rsp;
    logic      afu_almfull;
    shim_err_t shim_error;

    // Beats seen on bb_tx, beats sent, tags seen on afu_rsp
    wr_beat_t           tx_seen[$];
    wr_beat_t           exp_q[$];
    logic [MDATA_W-1:0] rsp_seen[$];

    int err_count;
    int tests_run;
    int tests_failed;

    wr_shim_top i_wr_shim_top (
        .afu_clk       (afu_clk),
        .afu_softreset (afu_softreset),
        .bb_clk        (bb_clk),
        .afu_tx        (afu_tx),
        .bb_almfull    (bb_almfull),
        .bb_rsp        (bb_rsp),
        .bb_tx         (bb_tx),
        .afu_rsp       (afu_rsp),
        .afu_almfull   (afu_almfull),
        .shim_error    (shim_error)
    );

    initial
    begin
        afu_clk = 1'b0;
        forever #(AFU_HALF) afu_clk = ~afu_clk;
    end

    initial
    begin
        bb_clk = 1'b0;
        forever #(BB_HALF) bb_clk = ~bb_clk;
    end

    // Outputs are registered, so mid-cycle sampling sees settled values
    always @(negedge bb_clk)
    begin
        if (bb_tx.valid)
        begin
            tx_seen.push_back(bb_tx);
        end
    end

    always @(negedge afu_clk)
    begin
        if (afu_rsp.valid)
        begin
            rsp_seen.push_back(afu_rsp.mdata);
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    function automatic wr_beat_t make_beat(input req_kind_t kind, input logic sop,
                                           input cl_len_t len, input logic [MDATA_W-1:0] tag);
        wr_beat_t b;
        b.valid      = 1'b1;
        b.hdr.kind   = kind;
        b.hdr.sop    = sop;
        b.hdr.cl_len = len;
        b.hdr.addr   = ADDR_W'($urandom());
        b.hdr.mdata  = tag;
        b.data       = {$urandom(), $urandom()};
        return b;
    endfunction

    // Reset also lets the bb_clk reset synchronizer release
    task automatic apply_reset();
        @(negedge afu_clk);
        afu_softreset = 1'b1;
        afu_tx        = '0;
        repeat (RESET_CYCLES) @(negedge afu_clk);
        afu_softreset = 1'b0;
        repeat (4) @(negedge afu_clk);
        tx_seen.delete();
        exp_q.delete();
        rsp_seen.delete();
    endtask

    // One beat for exactly one afu_clk cycle
    task automatic send_beat(input wr_beat_t b);
        @(negedge afu_clk);
        afu_tx = b;
        exp_q.push_back(b);
    endtask

    task automatic idle_afu();
        @(negedge afu_clk);
        afu_tx = '0;
    endtask

    task automatic send_rsp(input logic [MDATA_W-1:0] tag);
        @(negedge bb_clk);
        bb_rsp.valid = 1'b1;
        bb_rsp.mdata = tag;
    endtask

    task automatic wait_beats(input int n, input int max_cycles);
        int cycles;
        cycles = 0;
        while (tx_seen.size() < n && cycles < max_cycles)
        begin
            @(posedge bb_clk);
            cycles++;
        end
        if (tx_seen.size() < n)
        begin
            $display("Timed out waiting for %0d beats on bb_tx, saw %0d", n, tx_seen.size());
            err_count++;
        end
    endtask

    task automatic wait_rsps(input int n, input int max_cycles);
        int cycles;
        cycles = 0;
        while (rsp_seen.size() < n && cycles < max_cycles)
        begin
            @(posedge afu_clk);
            cycles++;
        end
        if (rsp_seen.size() < n)
        begin
            $display("Timed out waiting for %0d responses, saw %0d", n, rsp_seen.size());
            err_count++;
        end
    endtask

    // Beats must leave whole and in the order they went in
    task automatic compare_beats();
        if (tx_seen.size() != exp_q.size())
        begin
            $display("bb_tx carried %0d beats where %0d were sent", tx_seen.size(), exp_q.size());
            err_count++;
        end
        for (int i = 0; i < exp_q.size() && i < tx_seen.size(); i++)
        begin
            if (tx_seen[i].hdr !== exp_q[i].hdr)
            begin
                $display("[ERROR] bb_tx.hdr beat %0d: expected %h, got %h",
                         i, exp_q[i].hdr, tx_seen[i].hdr);
                err_count++;
            end
            if (tx_seen[i].data !== exp_q[i].data)
            begin
                $display("[ERROR] bb_tx.data beat %0d: expected %h, got %h",
                         i, exp_q[i].data, tx_seen[i].data);
                err_count++;
            end
        end
    endtask

    task automatic end_test(input string name, input int start_errs);
        tests_run++;
        if (err_count == start_errs)
        begin
            $display("[TEST] %s passed", name);
        end
        else
        begin
            $display("[TEST] %s failed with %0d errors", name, err_count - start_errs);
            tests_failed++;
        end
    endtask

    task automatic test_reset_state();
        int start_errs;
        start_errs = err_count;
        apply_reset();
        @(negedge afu_clk);
        if (bb_tx.valid !== 1'b0)
        begin
            $display("[ERROR] bb_tx.valid: expected %h, got %h", 1'b0, bb_tx.valid);
            err_count++;
        end
        if (afu_rsp.valid !== 1'b0)
        begin
            $display("[ERROR] afu_rsp.valid: expected %h, got %h", 1'b0, afu_rsp.valid);
            err_count++;
        end
        if (afu_almfull !== 1'b0)
        begin
            $display("[ERROR] afu_almfull: expected %h, got %h", 1'b0, afu_almfull);
            err_count++;
        end
        if (shim_error !== 2'b00)
        begin
            $display("[ERROR] shim_error: expected %h, got %h", 2'b00, shim_error);
            err_count++;
        end
        end_test("reset_state", start_errs);
    endtask

    task automatic test_single_lines();
        int start_errs;
        start_errs = err_count;
        apply_reset();
        for (int i = 0; i < 6; i++)
        begin
            send_beat(make_beat(wrline_i, 1'b1, 2'd0, MDATA_W'(8'h10 + i)));
        end
        idle_afu();
        wait_beats(6, 80);
        compare_beats();
        end_test("single_lines", start_errs);
    endtask

    // Link almost-full rises once the 4-line write has begun
    task automatic test_packet_integrity();
        int start_errs;
        start_errs = err_count;
        apply_reset();
        fork
            begin
                for (int i = 0; i < 4; i++)
                begin
                    send_beat(make_beat(wrline_m, (i == 0), 2'd3, MDATA_W'(8'h30)));
                end
                send_beat(make_beat(wrline_i, 1'b1, 2'd0, MDATA_W'(8'h31)));
                idle_afu();
            end
            begin
                wait_beats(1, 60);
                @(negedge bb_clk);
                bb_almfull = 1'b1;
            end
        join
        wait_beats(4, 80);
        repeat (30) @(posedge bb_clk);
        if (tx_seen.size() != 4)
        begin
            $display("bb_tx carried %0d beats under bb_almfull, the 4-line write alone was due",
                     tx_seen.size());
            err_count++;
        end
        @(negedge bb_clk);
        bb_almfull = 1'b0;
        wait_beats(5, 60);
        compare_beats();
        end_test("packet_integrity", start_errs);
    endtask

    task automatic test_credits();
        int   start_errs;
        int   cycles;
        logic seen;
        start_errs = err_count;
        apply_reset();
        for (int i = 0; i < 9; i++)
        begin
            while (afu_almfull)
            begin
                idle_afu();
            end
            send_beat(make_beat(wrline_i, 1'b1, 2'd0, MDATA_W'(8'h40 + i)));
        end
        // Ninth outstanding line is past the credit limit
        seen = 1'b0;
        for (int c = 0; c < 3; c++)
        begin
            idle_afu();
            if (afu_almfull)
            begin
                seen = 1'b1;
            end
        end
        if (!seen)
        begin
            $display("afu_almfull did not rise within 3 cycles after the ninth write");
            err_count++;
        end
        wait_beats(9, 80);
        compare_beats();
        for (int i = 0; i < 9; i++)
        begin
            send_rsp(MDATA_W'(8'h40 + i));
        end
        @(negedge bb_clk);
        bb_rsp = '0;
        wait_rsps(9, 60);
        if (rsp_seen.size() != 9)
        begin
            $display("afu_rsp carried %0d responses where 9 were returned", rsp_seen.size());
            err_count++;
        end
        for (int i = 0; i < rsp_seen.size(); i++)
        begin
            if (rsp_seen[i] !== MDATA_W'(8'h40 + i))
            begin
                $display("[ERROR] afu_rsp.mdata response %0d: expected %h, got %h",
                         i, MDATA_W'(8'h40 + i), rsp_seen[i]);
                err_count++;
            end
        end
        cycles = 0;
        while (afu_almfull && cycles < 10)
        begin
            @(negedge afu_clk);
            cycles++;
        end
        if (afu_almfull)
        begin
            $display("afu_almfull stayed high after all responses came back");
            err_count++;
        end
        end_test("credits", start_errs);
    endtask

    // Sender ignores almost-full while the link holds everything back
    task automatic test_overflow();
        int start_errs;
        start_errs = err_count;
        apply_reset();
        @(negedge bb_clk);
        bb_almfull = 1'b1;
        for (int i = 0; i < 20; i++)
        begin
            send_beat(make_beat(wrline_i, 1'b1, 2'd0, MDATA_W'(8'h60 + i)));
        end
        idle_afu();
        for (int pass = 0; pass < 2; pass++)
        begin
            repeat (12) idle_afu();
            if (shim_error.tx_overflow !== 1'b1)
            begin
                $display("[ERROR] shim_error.tx_overflow: expected %h, got %h",
                         1'b1, shim_error.tx_overflow);
                err_count++;
            end
            if (afu_almfull !== 1'b1)
            begin
                $display("[ERROR] afu_almfull: expected %h, got %h", 1'b1, afu_almfull);
                err_count++;
            end
        end
        if (tx_seen.size() != 0)
        begin
            $display("A beat left on bb_tx while bb_almfull was high");
            err_count++;
        end
        apply_reset();
        if (shim_error !== 2'b00)
        begin
            $display("[ERROR] shim_error: expected %h, got %h", 2'b00, shim_error);
            err_count++;
        end
        if (afu_almfull !== 1'b0)
        begin
            $display("[ERROR] afu_almfull: expected %h, got %h", 1'b0, afu_almfull);
            err_count++;
        end
        @(negedge bb_clk);
        bb_almfull = 1'b0;
        end_test("overflow", start_errs);
    endtask

    initial
    begin
        void'($urandom(32'h6c5));
        afu_softreset = 1'b1;
        afu_tx        = '0;
        bb_almfull    = 1'b0;
        bb_rsp        = '0;
        err_count     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        test_reset_state();
        test_single_lines();
        test_packet_integrity();
        test_credits();
        test_overflow();
        $display("Summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, err_count);
        if (err_count == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
source/wr_shim_pkg.sv
source/cdc_fifo.sv
source/wr_req_intake.sv
source/wr_req_issue.sv
source/wr_shim_top.sv
bench/tb_wr_shim.sv

// ==== run.sh ====
#!/bin/sh
# Compile the write shim and its testbench with Verilator, run, then scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_wr_shim -f build.f -o sim_wr_shim

# The log decides the result, so a stopped simulation still gets scanned
./obj_dir/sim_wr_shim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation ended without a final result line"
    exit 1
fi

// ==== source/cdc_fifo.sv ====
// *******************
// Dual-clock FIFO with gray-coded pointers crossing through two-flop synchronizers
// Write side reports full and fill level, read side shows the head entry directly
// *******************

`timescale 1ns/1ps
`default_nettype none

module cdc_fifo
#(
    parameter int WIDTH       = 8,
    parameter int DEPTH_RADIX = 4
)
(
    input  wire logic                   wr_clk,
    input  wire logic                   wr_rst,
    input  wire logic                   wr_en,
    input  wire logic [WIDTH-1:0]       wr_data,
    output logic                        wr_full,
    output logic [DEPTH_RADIX:0]        wr_level,

    input  wire logic                   rd_clk,
    input  wire logic                   rd_rst,
    input  wire logic                   rd_en,
    output logic [WIDTH-1:0]            rd_data,
    output logic                        rd_empty
);

    // Storage, no reset
    logic [WIDTH-1:0] mem [2**DEPTH_RADIX];

    // Pointers carry one extra bit to tell full from empty
    logic [DEPTH_RADIX:0] wr_bin;
    logic [DEPTH_RADIX:0] wr_gray;
    logic [DEPTH_RADIX:0] wr_bin_next;
    logic [DEPTH_RADIX:0] rd_bin;
    logic [DEPTH_RADIX:0] rd_gray;
    logic [DEPTH_RADIX:0] rd_bin_next;

    // Synchronizer stages for the opposite pointer
    logic [DEPTH_RADIX:0] rd_gray_meta;
    logic [DEPTH_RADIX:0] rd_gray_wr;
    logic [DEPTH_RADIX:0] wr_gray_meta;
    logic [DEPTH_RADIX:0] wr_gray_rd;

    logic wr_accept;
    logic rd_accept;

    function automatic logic [DEPTH_RADIX:0] bin2gray(input logic [DEPTH_RADIX:0] b);
        return b ^ (b >> 1);
    endfunction

    function automatic logic [DEPTH_RADIX:0] gray2bin(input logic [DEPTH_RADIX:0] g);
        logic [DEPTH_RADIX:0] b;
        b[DEPTH_RADIX] = g[DEPTH_RADIX];
        for (int i = DEPTH_RADIX - 1; i >= 0; i--)
        begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // Write side, a write into a full FIFO is dropped
    assign wr_accept   = wr_en && !wr_full;
    assign wr_bin_next = wr_bin + 1'b1;

    always_ff @(posedge wr_clk)
    begin
        if (wr_rst)
        begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end
        else if (wr_accept)
        begin
            wr_bin  <= wr_bin_next;
            wr_gray <= bin2gray(wr_bin_next);
        end
    end

    always_ff @(posedge wr_clk)
    begin
        if (wr_accept)
        begin
            mem[wr_bin[DEPTH_RADIX-1:0]] <= wr_data;
        end
    end

    // Read pointer into the write clock
    always_ff @(posedge wr_clk)
    begin
        if (wr_rst)
        begin
            rd_gray_meta <= '0;
            rd_gray_wr   <= '0;
        end
        else
        begin
            rd_gray_meta <= rd_gray;
            rd_gray_wr   <= rd_gray_meta;
        end
    end

    // Level is pessimistic by the synchronizer delay
    assign wr_level = wr_bin - gray2bin(rd_gray_wr);
    // Level never exceeds the depth, so the top bit alone means full
    assign wr_full  = wr_level[DEPTH_RADIX];

    // Read side
    assign rd_accept   = rd_en && !rd_empty;
    assign rd_bin_next = rd_bin + 1'b1;

    always_ff @(posedge rd_clk)
    begin
        if (rd_rst)
        begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end
        else if (rd_accept)
        begin
            rd_bin  <= rd_bin_next;
            rd_gray <= bin2gray(rd_bin_next);
        end
    end

    // Write pointer into the read clock
    always_ff @(posedge rd_clk)
    begin
        if (rd_rst)
        begin
            wr_gray_meta <= '0;
            wr_gray_rd   <= '0;
        end
        else
        begin
            wr_gray_meta <= wr_gray;
            wr_gray_rd   <= wr_gray_meta;
        end
    end

    assign rd_empty = (rd_gray == wr_gray_rd);
    // Head entry, valid in the cycle of the pop
    assign rd_data  = mem[rd_bin[DEPTH_RADIX-1:0]];

    // Reader must look at empty before popping
    a_no_read_empty: assert property (@(posedge rd_clk) disable iff (rd_rst)
        rd_en |-> !rd_empty);

endmodule

`default_nettype wire

// ==== source/wr_req_intake.sv ====
// *******************
// Accelerator-side intake of the write shim, on afu_clk
// Registers request beats into the request FIFO, returns responses,
// counts outstanding lines and raises almost-full
// *******************

`timescale 1ns/1ps
`default_nettype none

module wr_req_intake
    import wr_shim_pkg::*;
(
    input  wire logic                    afu_clk,
    input  wire logic                    afu_softreset,
    input  wire wr_beat_t                afu_tx,
    input  wire logic [TX_DEPTH_RADIX:0] fifo_level,
    input  wire logic                    fifo_full,
    input  wire wr_rsp_t                 rsp_data,
    input  wire logic                    rsp_empty,
    input  wire logic                    rx_overflow_bb,
    output logic                         fifo_wr_en,
    output wr_entry_t                    fifo_wr_data,
    output logic                         rsp_rd_en,
    output wr_rsp_t                      afu_rsp,
    output logic                         afu_almfull,
    output shim_err_t                    shim_error
);

    // Input register
    logic                tx_valid_q;
    wr_entry_t           tx_entry_q;
    // Response output register
    logic                rsp_valid_q;
    logic [MDATA_W-1:0]  rsp_mdata_q;
    // Outstanding lines
    logic [CREDIT_W-1:0] credit_cnt;
    logic                credit_inc;
    logic                credit_dec;
    // First stage of the rx_overflow synchronizer
    logic                rx_ovf_meta;

    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            tx_valid_q <= 1'b0;
        end
        else
        begin
            tx_valid_q <= afu_tx.valid;
        end
    end

    always_ff @(posedge afu_clk)
    begin
        tx_entry_q.hdr  <= afu_tx.hdr;
        tx_entry_q.data <= afu_tx.data;
    end

    // Every registered beat goes to the FIFO, full drops it there
    assign fifo_wr_en   = tx_valid_q;
    assign fifo_wr_data = tx_entry_q;

    // Drain responses as soon as they show up
    assign rsp_rd_en = !rsp_empty;

    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            rsp_valid_q <= rsp_rd_en && rsp_data.valid;
        end
    end

    always_ff @(posedge afu_clk)
    begin
        rsp_mdata_q <= rsp_data.mdata;
    end

    always_comb
    begin
        afu_rsp.valid = rsp_valid_q;
        afu_rsp.mdata = rsp_mdata_q;
    end

    // Count only beats that really entered the FIFO
    assign credit_inc = fifo_wr_en && !fifo_full;
    assign credit_dec = rsp_valid_q;

    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            credit_cnt <= '0;
        end
        else if (credit_inc && !credit_dec)
        begin
            credit_cnt <= credit_cnt + 1'b1;
        end
        else if (!credit_inc && credit_dec)
        begin
            credit_cnt <= credit_cnt - 1'b1;
        end
    end

    // Sticky errors, rx side comes over from bb_clk through two flops
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            shim_error  <= '0;
            rx_ovf_meta <= 1'b0;
        end
        else
        begin
            shim_error.tx_overflow <= shim_error.tx_overflow || (fifo_wr_en && fifo_full);
            rx_ovf_meta            <= rx_overflow_bb;
            shim_error.rx_overflow <= rx_ovf_meta;
        end
    end

    // Almost-full, any error stops all traffic until reset
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            afu_almfull <= 1'b0;
        end
        else
        begin
            afu_almfull <= (fifo_level >= TX_ALMFULL_LEVEL) ||
                           (credit_cnt > CREDIT_LIMIT) ||
                           (|shim_error);
        end
    end

    // A response never returns for a line that was not sent
    a_credit_no_underflow: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        credit_dec |-> (credit_cnt != '0) || credit_inc);

endmodule

`default_nettype wire

// ==== source/wr_req_issue.sv ====
// *******************
// Link-side issue stage of the write shim, on bb_clk
// Pops the request FIFO into a registered bb_tx and keeps multi-line
// writes whole under link almost-full
// *******************

`timescale 1ns/1ps
`default_nettype none

module wr_req_issue
    import wr_shim_pkg::*;
(
    input  wire logic      bb_clk,
    input  wire logic      afu_softreset,
    input  wire wr_entry_t fifo_data,
    input  wire logic      fifo_empty,
    input  wire logic      bb_almfull,
    input  wire wr_rsp_t   bb_rsp,
    input  wire logic      rsp_full,
    output logic           bb_reset,
    output logic           fifo_rd_en,
    output wr_beat_t       bb_tx,
    output logic           rx_overflow_bb
);

    // Reset synchronizer stages
    logic [2:0] reset_pipe;
    // Output register, valid doubles as last-cycle pop flag
    logic       tx_valid_q;
    wr_entry_t  tx_entry_q;
    // Packet tracking on beats that leave
    logic       in_packet;
    cl_len_t    rem_beats;
    logic       multi_beat;

    // afu_softreset into bb_clk
    always_ff @(posedge bb_clk)
    begin
        reset_pipe <= {reset_pipe[1:0], afu_softreset};
    end

    assign bb_reset = reset_pipe[2];

    // Under link almost-full only finish the packet in flight
    // One pop every other cycle there, the bubbles do not matter
    assign fifo_rd_en = !fifo_empty && (!bb_almfull || (in_packet && !tx_valid_q));

    always_ff @(posedge bb_clk)
    begin
        if (bb_reset)
        begin
            tx_valid_q <= 1'b0;
        end
        else
        begin
            tx_valid_q <= fifo_rd_en;
        end
    end

    always_ff @(posedge bb_clk)
    begin
        tx_entry_q <= fifo_data;
    end

    always_comb
    begin
        bb_tx.valid = tx_valid_q;
        bb_tx.hdr   = tx_entry_q.hdr;
        bb_tx.data  = tx_entry_q.data;
    end

    // Start of a write longer than one line
    assign multi_beat = tx_entry_q.hdr.sop &&
                        (tx_entry_q.hdr.cl_len != cl_len_t'(0)) &&
                        ((tx_entry_q.hdr.kind == wrline_i) ||
                         (tx_entry_q.hdr.kind == wrline_m));

    always_ff @(posedge bb_clk)
    begin
        if (bb_reset)
        begin
            in_packet <= 1'b0;
            rem_beats <= '0;
        end
        else if (tx_valid_q)
        begin
            if (in_packet)
            begin
                // Last beat when one remains
                in_packet <= (rem_beats != cl_len_t'(1));
                rem_beats <= rem_beats - 1'b1;
            end
            else
            begin
                in_packet <= multi_beat;
                rem_beats <= tx_entry_q.hdr.cl_len;
            end
        end
    end

    // Response dropped at a full response FIFO, sticky
    always_ff @(posedge bb_clk)
    begin
        if (bb_reset)
        begin
            rx_overflow_bb <= 1'b0;
        end
        else
        begin
            rx_overflow_bb <= rx_overflow_bb || (bb_rsp.valid && rsp_full);
        end
    end

    // Packets never interleave on the link
    a_no_sop_in_packet: assert property (@(posedge bb_clk) disable iff (bb_reset)
        (tx_valid_q && tx_entry_q.hdr.sop) |-> !in_packet);

endmodule

`default_nettype wire

// ==== source/wr_shim_pkg.sv ====
// *******************
// Shared widths, limits and beat types for the write-path clock-crossing shim
// Every RTL file of the shim imports this package with a wildcard import
// *******************

`default_nettype none

package wr_shim_pkg;

    // Payload and header field widths
    localparam int DATA_W  = 64;
    localparam int ADDR_W  = 16;
    localparam int MDATA_W = 8;

    // FIFO depths as log2 of the entry count
    localparam int TX_DEPTH_RADIX = 4;
    localparam int RX_DEPTH_RADIX = 4;

    // Outstanding-line counter width, with headroom past the response FIFO depth
    localparam int CREDIT_W = RX_DEPTH_RADIX + 1;

    // Request FIFO fill level that raises almost-full
    localparam logic [TX_DEPTH_RADIX:0] TX_ALMFULL_LEVEL = 10;

    // Outstanding lines above this raise almost-full
    // Must stay below the response FIFO depth
    localparam logic [CREDIT_W-1:0] CREDIT_LIMIT = 8;

    typedef enum logic [1:0] {
        wrline_i = 2'd0,
        wrline_m = 2'd1,
        wrfence  = 2'd2
    } req_kind_t;

    // Line count minus one
    typedef logic [1:0] cl_len_t;

    typedef struct packed {
        req_kind_t          kind;
        logic               sop;
        cl_len_t            cl_len;
        logic [ADDR_W-1:0]  addr;
        logic [MDATA_W-1:0] mdata;
    } wr_hdr_t;

    // One FIFO entry on the request path
    typedef struct packed {
        wr_hdr_t           hdr;
        logic [DATA_W-1:0] data;
    } wr_entry_t;

    typedef struct packed {
        logic              valid;
        wr_hdr_t           hdr;
        logic [DATA_W-1:0] data;
    } wr_beat_t;

    typedef struct packed {
        logic               valid;
        logic [MDATA_W-1:0] mdata;
    } wr_rsp_t;

    typedef struct packed {
        logic tx_overflow;
        logic rx_overflow;
    } shim_err_t;

endpackage

`default_nettype wire

// ==== source/wr_shim_top.sv ====
// *******************
// Write-path clock-crossing shim between accelerator (afu_clk) and link (bb_clk)
// Request beats cross one FIFO, write responses cross back through another
// *******************

`timescale 1ns/1ps
`default_nettype none

module wr_shim_top
    import wr_shim_pkg::*;
(
    input  wire logic     afu_clk,
    input  wire logic     afu_softreset,
    input  wire logic     bb_clk,
    input  wire wr_beat_t afu_tx,
    input  wire logic     bb_almfull,
    input  wire wr_rsp_t  bb_rsp,
    output wr_beat_t      bb_tx,
    output wr_rsp_t       afu_rsp,
    output logic          afu_almfull,
    output shim_err_t     shim_error
);

    // Request FIFO, afu_clk in, bb_clk out
    logic                    tx_wr_en;
    wr_entry_t               tx_wr_data;
    logic                    tx_full;
    logic [TX_DEPTH_RADIX:0] tx_level;
    logic                    tx_rd_en;
    wr_entry_t               tx_rd_data;
    logic                    tx_empty;
    // Response FIFO, bb_clk in, afu_clk out
    logic                    rsp_full;
    logic                    rsp_rd_en;
    wr_rsp_t                 rsp_rd_data;
    logic                    rsp_empty;
    // Link-side reset and error flag
    logic                    bb_reset;
    logic                    rx_overflow_bb;

    wr_req_intake i_intake (
        .afu_clk        (afu_clk),
        .afu_softreset  (afu_softreset),
        .afu_tx         (afu_tx),
        .fifo_level     (tx_level),
        .fifo_full      (tx_full),
        .rsp_data       (rsp_rd_data),
        .rsp_empty      (rsp_empty),
        .rx_overflow_bb (rx_overflow_bb),
        .fifo_wr_en     (tx_wr_en),
        .fifo_wr_data   (tx_wr_data),
        .rsp_rd_en      (rsp_rd_en),
        .afu_rsp        (afu_rsp),
        .afu_almfull    (afu_almfull),
        .shim_error     (shim_error)
    );

    cdc_fifo #(.WIDTH($bits(wr_entry_t)), .DEPTH_RADIX(TX_DEPTH_RADIX)) tx_fifo (
        .wr_clk   (afu_clk),
        .wr_rst   (afu_softreset),
        .wr_en    (tx_wr_en),
        .wr_data  (tx_wr_data),
        .wr_full  (tx_full),
        .wr_level (tx_level),
        .rd_clk   (bb_clk),
        .rd_rst   (bb_reset),
        .rd_en    (tx_rd_en),
        .rd_data  (tx_rd_data),
        .rd_empty (tx_empty)
    );

    // Responses go straight in, the level is not needed here
    cdc_fifo #(.WIDTH($bits(wr_rsp_t)), .DEPTH_RADIX(RX_DEPTH_RADIX)) rsp_fifo (
        .wr_clk   (bb_clk),
        .wr_rst   (bb_reset),
        .wr_en    (bb_rsp.valid),
        .wr_data  (bb_rsp),
        .wr_full  (rsp_full),
        .wr_level (),
        .rd_clk   (afu_clk),
        .rd_rst   (afu_softreset),
        .rd_en    (rsp_rd_en),
        .rd_data  (rsp_rd_data),
        .rd_empty (rsp_empty)
    );

    wr_req_issue i_issue (
        .bb_clk         (bb_clk),
        .afu_softreset  (afu_softreset),
        .fifo_data      (tx_rd_data),
        .fifo_empty     (tx_empty),
        .bb_almfull     (bb_almfull),
        .bb_rsp         (bb_rsp),
        .rsp_full       (rsp_full),
        .bb_reset       (bb_reset),
        .fifo_rd_en     (tx_rd_en),
        .bb_tx          (bb_tx),
        .rx_overflow_bb (rx_overflow_bb)
    );

endmodule

`default_nettype wire
